//--- source/axi_xbar_pkg.sv
package axi_xbar_pkg;

localparam int N_MST   = 2;
localparam int N_SLV   = 2;
localparam int SEL_W   = 1;

localparam int ID_W    = 4;
localparam int ADDR_W  = 32;
localparam int DATA_W  = 32;
localparam int LEN_W   = 8;
localparam int BURST_W = 2;
localparam int RESP_W  = 2;
localparam int STRB_W  = DATA_W / 8;

localparam int SLV_BIT = ADDR_W - 1;             // the top address bit picks the slave.

localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;

// write address beat.
typedef struct packed {
    logic [ID_W-1:0]    id;
    logic [ADDR_W-1:0]  addr;
    logic [LEN_W-1:0]   len;                     // beats in the burst minus one.
    logic [BURST_W-1:0] burst;                   // carried through untouched.
} axi_aw_t;

typedef axi_aw_t axi_ar_t;                       // a read address has the same layout.

typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
} axi_w_t;

typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [RESP_W-1:0] resp;
} axi_b_t;

typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic [RESP_W-1:0] resp;
    logic              last;
} axi_r_t;

// everything a master drives onto a port.
typedef struct packed {
    axi_aw_t aw;
    logic    aw_valid;
    axi_w_t  w;
    logic    w_valid;
    logic    b_ready;
    axi_ar_t ar;
    logic    ar_valid;
    logic    r_ready;
} axi_req_t;

// everything a slave drives back.
typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    axi_b_t  b;
    logic    b_valid;
    logic    ar_ready;
    axi_r_t  r;
    logic    r_valid;
} axi_resp_t;

endpackage

//--- source/axi_master_switch.sv
module axi_master_switch (
    input  logic [axi_xbar_pkg::SEL_W-1:0] wr_sel,
    input  logic [axi_xbar_pkg::SEL_W-1:0] rd_sel,
    input  logic                           wr_grant,
    input  logic                           rd_grant,
    input  axi_xbar_pkg::axi_req_t         mst_req  [axi_xbar_pkg::N_MST],
    output axi_xbar_pkg::axi_resp_t        mst_resp [axi_xbar_pkg::N_MST],
    input  axi_xbar_pkg::axi_resp_t        bus_resp,
    output axi_xbar_pkg::axi_req_t         bus_req
);

logic [axi_xbar_pkg::N_MST-1:0] wr_on;           // master owns the write path.
logic [axi_xbar_pkg::N_MST-1:0] rd_on;           // master owns the read path.

always_comb begin
    for (int i = 0; i < axi_xbar_pkg::N_MST; i++) begin
        wr_on[i] = wr_grant && (wr_sel == i);
        rd_on[i] = rd_grant && (rd_sel == i);
    end
end

// the owning master's fields go onto the shared bus.
always_comb begin
    bus_req = '0;
    for (int i = 0; i < axi_xbar_pkg::N_MST; i++) begin
        if (wr_on[i]) begin
            bus_req.aw       = mst_req[i].aw;
            bus_req.aw_valid = mst_req[i].aw_valid;
            bus_req.w        = mst_req[i].w;
            bus_req.w_valid  = mst_req[i].w_valid;
            bus_req.b_ready  = mst_req[i].b_ready;
        end
        if (rd_on[i]) begin
            bus_req.ar       = mst_req[i].ar;
            bus_req.ar_valid = mst_req[i].ar_valid;
            bus_req.r_ready  = mst_req[i].r_ready;
        end
    end
end

always_comb begin
    for (int i = 0; i < axi_xbar_pkg::N_MST; i++) begin
        mst_resp[i] = '0;                        // a waiting master sees all zeros.
        if (wr_on[i]) begin
            mst_resp[i].aw_ready = bus_resp.aw_ready;
            mst_resp[i].w_ready  = bus_resp.w_ready;
            mst_resp[i].b        = bus_resp.b;
            mst_resp[i].b_valid  = bus_resp.b_valid;
        end
        if (rd_on[i]) begin
            mst_resp[i].ar_ready = bus_resp.ar_ready;
            mst_resp[i].r        = bus_resp.r;
            mst_resp[i].r_valid  = bus_resp.r_valid;
        end
    end
end

// a slave's handshake must never leak to a master that does not own the path.
for (genvar i = 0; i < axi_xbar_pkg::N_MST; i++) begin : g_iso
    assert final (wr_on[i] ||
                  !(mst_resp[i].aw_ready || mst_resp[i].w_ready || mst_resp[i].b_valid))
        else $error("master %0d sees a write handshake without the write grant", i);
    assert final (rd_on[i] ||
                  !(mst_resp[i].ar_ready || mst_resp[i].r_valid))
        else $error("master %0d sees a read handshake without the read grant", i);
end

endmodule

//--- source/axi_slave_switch.sv
module axi_slave_switch (
    input  logic [axi_xbar_pkg::SEL_W-1:0] wr_sel,
    input  logic [axi_xbar_pkg::SEL_W-1:0] rd_sel,
    input  logic                           wr_grant,
    input  logic                           rd_grant,
    input  axi_xbar_pkg::axi_req_t         bus_req,
    output axi_xbar_pkg::axi_resp_t        bus_resp,
    output axi_xbar_pkg::axi_req_t         slv_req  [axi_xbar_pkg::N_SLV],
    input  axi_xbar_pkg::axi_resp_t        slv_resp [axi_xbar_pkg::N_SLV]
);

logic [axi_xbar_pkg::N_SLV-1:0] wr_on;
logic [axi_xbar_pkg::N_SLV-1:0] rd_on;
logic [axi_xbar_pkg::N_SLV-1:0] aw_seen;         // aw_valid as each slave sees it.
logic [axi_xbar_pkg::N_SLV-1:0] ar_seen;

always_comb begin
    for (int j = 0; j < axi_xbar_pkg::N_SLV; j++) begin
        wr_on[j] = wr_grant && (wr_sel == j);
        rd_on[j] = rd_grant && (rd_sel == j);
    end
end

always_comb begin
    for (int j = 0; j < axi_xbar_pkg::N_SLV; j++) begin
        slv_req[j] = '0;
        if (wr_on[j]) begin
            slv_req[j].aw       = bus_req.aw;
            slv_req[j].aw_valid = bus_req.aw_valid;
            slv_req[j].w        = bus_req.w;
            slv_req[j].w_valid  = bus_req.w_valid;
            slv_req[j].b_ready  = bus_req.b_ready;
        end
        if (rd_on[j]) begin
            slv_req[j].ar       = bus_req.ar;
            slv_req[j].ar_valid = bus_req.ar_valid;
            slv_req[j].r_ready  = bus_req.r_ready;
        end
        aw_seen[j] = slv_req[j].aw_valid;
        ar_seen[j] = slv_req[j].ar_valid;
    end
end

always_comb begin
    bus_resp = '0;
    for (int j = 0; j < axi_xbar_pkg::N_SLV; j++) begin
        if (wr_on[j]) begin
            bus_resp.aw_ready = slv_resp[j].aw_ready;
            bus_resp.w_ready  = slv_resp[j].w_ready;
            bus_resp.b        = slv_resp[j].b;
            bus_resp.b_valid  = slv_resp[j].b_valid;
        end
        if (rd_on[j]) begin
            bus_resp.ar_ready = slv_resp[j].ar_ready;
            bus_resp.r        = slv_resp[j].r;
            bus_resp.r_valid  = slv_resp[j].r_valid;
        end
    end
end

assert final ($onehot0(aw_seen))
    else $error("more than one slave sees aw_valid");
assert final ($onehot0(ar_seen))
    else $error("more than one slave sees ar_valid");

endmodule

//--- source/axi_txn_arbiter.sv
module axi_txn_arbiter (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [axi_xbar_pkg::N_MST-1:0] req,
    input  logic [axi_xbar_pkg::N_MST-1:0] req_slv,
    input  logic                           done,
    output logic                           grant,
    output logic [axi_xbar_pkg::SEL_W-1:0] mst_sel,
    output logic [axi_xbar_pkg::SEL_W-1:0] slv_sel
);

logic [axi_xbar_pkg::SEL_W-1:0] last_sel;        // the search starts just after this master.
logic [axi_xbar_pkg::SEL_W-1:0] pick;
logic                           pick_valid;

// round-robin search where the nearest requester after last_sel wins.
always_comb begin
    int unsigned idx;

    pick       = last_sel;
    pick_valid = 1'b0;
    for (int k = axi_xbar_pkg::N_MST; k >= 1; k--) begin
        idx = (int'(last_sel) + k) % axi_xbar_pkg::N_MST;
        if (req[idx]) begin
            pick       = axi_xbar_pkg::SEL_W'(idx);
            pick_valid = 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        grant    <= 1'b0;
        mst_sel  <= '0;
        slv_sel  <= '0;
        last_sel <= axi_xbar_pkg::SEL_W'(axi_xbar_pkg::N_MST - 1); // so master 0 goes first.
    end else if (grant) begin
        if (done) begin
            grant <= 1'b0;                       // selects keep their value while idle.
        end
    end else if (pick_valid) begin
        grant    <= 1'b1;
        mst_sel  <= pick;
        slv_sel  <= req_slv[pick];
        last_sel <= pick;
    end
end

// the path must not switch under a transaction in flight.
assert property (@(posedge clk) disable iff (reset)
    grant |=> !grant || ($stable(mst_sel) && $stable(slv_sel)))
    else $error("arbiter selects moved while granted");

assert property (@(posedge clk)
    reset |=> !grant)
    else $error("arbiter grant not low after reset");

endmodule

//--- source/axi_xbar_top.sv
module axi_xbar_top (
    input  logic                    clk,
    input  logic                    reset,
    input  axi_xbar_pkg::axi_req_t  mst_req  [axi_xbar_pkg::N_MST],
    output axi_xbar_pkg::axi_resp_t mst_resp [axi_xbar_pkg::N_MST],
    output axi_xbar_pkg::axi_req_t  slv_req  [axi_xbar_pkg::N_SLV],
    input  axi_xbar_pkg::axi_resp_t slv_resp [axi_xbar_pkg::N_SLV]
);

axi_xbar_pkg::axi_req_t  bus_req;
axi_xbar_pkg::axi_resp_t bus_resp;

logic                           wr_grant;
logic [axi_xbar_pkg::SEL_W-1:0] wr_mst_sel;
logic [axi_xbar_pkg::SEL_W-1:0] wr_slv_sel;
logic                           rd_grant;
logic [axi_xbar_pkg::SEL_W-1:0] rd_mst_sel;
logic [axi_xbar_pkg::SEL_W-1:0] rd_slv_sel;

logic [axi_xbar_pkg::N_MST-1:0] wr_req;
logic [axi_xbar_pkg::N_MST-1:0] wr_req_slv;
logic [axi_xbar_pkg::N_MST-1:0] rd_req;
logic [axi_xbar_pkg::N_MST-1:0] rd_req_slv;
logic                           wr_done;
logic                           rd_done;

always_comb begin
    for (int i = 0; i < axi_xbar_pkg::N_MST; i++) begin
        wr_req[i]     = mst_req[i].aw_valid;
        wr_req_slv[i] = mst_req[i].aw.addr[axi_xbar_pkg::SLV_BIT];
        rd_req[i]     = mst_req[i].ar_valid;
        rd_req_slv[i] = mst_req[i].ar.addr[axi_xbar_pkg::SLV_BIT];
    end
end

assign wr_done = bus_req.b_ready && bus_resp.b_valid;                    // one B per burst.
assign rd_done = bus_req.r_ready && bus_resp.r_valid && bus_resp.r.last; // last R beat.

axi_txn_arbiter u_wr_arb (
    .clk     (clk),
    .reset   (reset),
    .req     (wr_req),
    .req_slv (wr_req_slv),
    .done    (wr_done),
    .grant   (wr_grant),
    .mst_sel (wr_mst_sel),
    .slv_sel (wr_slv_sel)
);

axi_txn_arbiter u_rd_arb (
    .clk     (clk),
    .reset   (reset),
    .req     (rd_req),
    .req_slv (rd_req_slv),
    .done    (rd_done),
    .grant   (rd_grant),
    .mst_sel (rd_mst_sel),
    .slv_sel (rd_slv_sel)
);

axi_master_switch u_mst_sw (
    .wr_sel   (wr_mst_sel),
    .rd_sel   (rd_mst_sel),
    .wr_grant (wr_grant),
    .rd_grant (rd_grant),
    .mst_req  (mst_req),
    .mst_resp (mst_resp),
    .bus_resp (bus_resp),
    .bus_req  (bus_req)
);

axi_slave_switch u_slv_sw (
    .wr_sel   (wr_slv_sel),
    .rd_sel   (rd_slv_sel),
    .wr_grant (wr_grant),
    .rd_grant (rd_grant),
    .bus_req  (bus_req),
    .bus_resp (bus_resp),
    .slv_req  (slv_req),
    .slv_resp (slv_resp)
);

endmodule

//--- testbench/axi_mem_model.sv
module axi_mem_model #(
    parameter logic [31:0] SEED = 32'd14
) (
    input  logic                    clk,
    input  logic                    reset,
    input  axi_xbar_pkg::axi_req_t  req,
    output axi_xbar_pkg::axi_resp_t resp
);

timeunit 1ns;
timeprecision 1ps;

typedef enum logic [1:0] {
    W_IDLE,
    W_DATA,
    W_RESP
} wr_state_t;

logic [31:0] mem [256];
logic [31:0] rnd;                                // stall source that advances every cycle.
wr_state_t   wr_state;
logic [7:0]  waddr;
logic [axi_xbar_pkg::ID_W-1:0] wid;
logic        rd_busy;
logic        r_go;                               // once set, r_valid holds until the transfer.
logic [7:0]  raddr;
logic [7:0]  rlen;
logic [7:0]  rcnt;
logic [axi_xbar_pkg::ID_W-1:0] rid;

function automatic logic [31:0] next_rand(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

initial begin
    for (int a = 0; a < 256; a++) begin
        mem[a] = {a[7:0], ~a[7:0], a[7:0] ^ 8'h5a, 8'hc3};
    end
end

always_comb begin
    resp          = '0;
    resp.aw_ready = (wr_state == W_IDLE) && !rnd[0];
    resp.w_ready  = (wr_state == W_DATA) && !rnd[1];
    resp.b.id     = wid;
    resp.b.resp   = axi_xbar_pkg::RESP_OKAY;
    resp.b_valid  = (wr_state == W_RESP);
    resp.ar_ready = !rd_busy && !rnd[2];
    resp.r.id     = rid;
    resp.r.data   = mem[raddr];
    resp.r.resp   = axi_xbar_pkg::RESP_OKAY;
    resp.r.last   = (rcnt == rlen);
    resp.r_valid  = rd_busy && r_go;
end

// byte lanes are written under the strobe.
always @(posedge clk) begin
    if (!reset && wr_state == W_DATA && req.w_valid && resp.w_ready) begin
        for (int b = 0; b < axi_xbar_pkg::STRB_W; b++) begin
            if (req.w.strb[b]) begin
                mem[waddr][8*b +: 8] <= req.w.data[8*b +: 8];
            end
        end
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        rnd      <= SEED;
        wr_state <= W_IDLE;
        waddr    <= '0;
        wid      <= '0;
        rd_busy  <= 1'b0;
        r_go     <= 1'b0;
        raddr    <= '0;
        rlen     <= '0;
        rcnt     <= '0;
        rid      <= '0;
    end else begin
        rnd <= next_rand(rnd);
        case (wr_state)
            W_IDLE: begin
                if (req.aw_valid && resp.aw_ready) begin
                    waddr    <= req.aw.addr[9:2];
                    wid      <= req.aw.id;
                    wr_state <= W_DATA;
                end
            end
            W_DATA: begin
                if (req.w_valid && resp.w_ready) begin
                    waddr <= waddr + 8'd1;
                    if (req.w.last) begin
                        wr_state <= W_RESP;
                    end
                end
            end
            default: begin
                if (req.b_ready) begin
                    wr_state <= W_IDLE;
                end
            end
        endcase
        if (!rd_busy) begin
            if (req.ar_valid && resp.ar_ready) begin
                rd_busy <= 1'b1;
                raddr   <= req.ar.addr[9:2];
                rid     <= req.ar.id;
                rlen    <= req.ar.len;
                rcnt    <= '0;
                r_go    <= rnd[3];
            end
        end else if (!r_go) begin
            r_go <= rnd[3];
        end else if (req.r_ready) begin
            if (resp.r.last) begin
                rd_busy <= 1'b0;
                r_go    <= 1'b0;
            end else begin
                raddr <= raddr + 8'd1;
                rcnt  <= rcnt + 8'd1;
                r_go  <= rnd[3];
            end
        end
    end
end

endmodule

//--- testbench/tb_axi_xbar.sv
module tb_axi_xbar;

timeunit 1ns;
timeprecision 1ps;

localparam int TIMEOUT = 2000;
localparam int N_ITER  = 8;

logic                    clk;
logic                    reset;
axi_xbar_pkg::axi_req_t  mst_req  [axi_xbar_pkg::N_MST];
axi_xbar_pkg::axi_resp_t mst_resp [axi_xbar_pkg::N_MST];
axi_xbar_pkg::axi_req_t  slv_req  [axi_xbar_pkg::N_SLV];
axi_xbar_pkg::axi_resp_t slv_resp [axi_xbar_pkg::N_SLV];

logic [31:0] shadow [logic [31:0]];              // expected memory keyed by byte address.
logic [31:0] rng [axi_xbar_pkg::N_MST];
logic [31:0] last_addr [axi_xbar_pkg::N_MST];
logic [7:0]  last_len [axi_xbar_pkg::N_MST];
logic        started;                            // set once any master has requested.
logic        aw_exp_v;
int          aw_exp;
logic        ar_exp_v;
int          ar_exp;
logic        quiet;
logic [1:0]  wr_seen;
logic [1:0]  rd_seen;

axi_xbar_top uut (
    .clk      (clk),
    .reset    (reset),
    .mst_req  (mst_req),
    .mst_resp (mst_resp),
    .slv_req  (slv_req),
    .slv_resp (slv_resp)
);

axi_mem_model #(.SEED(32'd14)) u_mem0 (.clk(clk), .reset(reset), .req(slv_req[0]),
                                      .resp(slv_resp[0]));
axi_mem_model #(.SEED(32'd14)) u_mem1 (.clk(clk), .reset(reset), .req(slv_req[1]),
                                      .resp(slv_resp[1]));

initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
end

function automatic logic [31:0] next_rand(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

task automatic report_error(input string msg);
    $display("ERR @%0t: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1);
endtask

task automatic report_timeout(input int m, input string what);
    $display("master %0d timed out while waiting for %s", m, what);
    $display("TEST FAILED");
    $fatal(1);
endtask

always_comb begin
    quiet = 1'b1;
    for (int k = 0; k < 2; k++) begin
        if (mst_resp[k].aw_ready || mst_resp[k].w_ready || mst_resp[k].ar_ready ||
            slv_req[k].aw_valid || slv_req[k].w_valid || slv_req[k].ar_valid) begin
            quiet = 1'b0;
        end
        wr_seen[k] = mst_resp[k].aw_ready || mst_resp[k].w_ready || mst_resp[k].b_valid;
        rd_seen[k] = mst_resp[k].ar_ready || mst_resp[k].r_valid;
    end
end

always @(posedge clk) begin
    if (reset) begin
        started <= 1'b0;
    end else if (mst_req[0].aw_valid || mst_req[1].aw_valid ||
                 mst_req[0].ar_valid || mst_req[1].ar_valid) begin
        started <= 1'b1;
    end
end

assert property (@(posedge clk) !started |-> quiet)
    else report_error("handshake activity before the first request");
assert property (@(posedge clk) disable iff (reset) !(wr_seen[0] && wr_seen[1]))
    else report_error("both masters see write responses at once");
assert property (@(posedge clk) disable iff (reset) !(rd_seen[0] && rd_seen[1]))
    else report_error("both masters see read responses at once");

for (genvar j = 0; j < 2; j++) begin : g_slv_chk
    assert property (@(posedge clk) disable iff (reset)
        slv_req[j].aw_valid |-> slv_req[j].aw.addr[31] == j)
        else report_error($sformatf("write burst reached slave %0d by mistake", j));
    assert property (@(posedge clk) disable iff (reset)
        slv_req[j].ar_valid |-> slv_req[j].ar.addr[31] == j)
        else report_error($sformatf("read burst reached slave %0d by mistake", j));
    // a stalled read beat must hold until the master takes it.
    assert property (@(posedge clk) disable iff (reset)
        mst_resp[j].r_valid && !mst_req[j].r_ready |=>
            mst_resp[j].r_valid && $stable(mst_resp[j].r))
        else report_error($sformatf("R beat to master %0d changed before transfer", j));
end

// with the other master waiting, the next grant must go to it.
always @(posedge clk) begin
    if (reset) begin
        aw_exp_v <= 1'b0;
        ar_exp_v <= 1'b0;
    end else begin
        for (int i = 0; i < 2; i++) begin
            if (mst_req[i].aw_valid && mst_resp[i].aw_ready) begin
                assert (!aw_exp_v || aw_exp == i)
                    else report_error($sformatf("AW order broken, master %0d went twice", i));
                aw_exp_v <= mst_req[1-i].aw_valid;
                aw_exp   <= 1 - i;
            end
            if (mst_req[i].ar_valid && mst_resp[i].ar_ready) begin
                assert (!ar_exp_v || ar_exp == i)
                    else report_error($sformatf("AR order broken, master %0d went twice", i));
                ar_exp_v <= mst_req[1-i].ar_valid;
                ar_exp   <= 1 - i;
            end
        end
    end
end

task automatic write_burst(input int m, input logic [31:0] addr, input logic [7:0] len);
    int t;
    logic [3:0] id;

    id = 4'(5 + m);
    @(negedge clk);
    mst_req[m].aw.id    = id;
    mst_req[m].aw.addr  = addr;
    mst_req[m].aw.len   = len;
    mst_req[m].aw.burst = 2'b01;
    mst_req[m].aw_valid = 1'b1;
    t = 0;
    do begin
        @(posedge clk);
        t++;
        if (t > TIMEOUT) report_timeout(m, "aw_ready");
    end while (!mst_resp[m].aw_ready);
    @(negedge clk);
    mst_req[m].aw_valid = 1'b0;
    for (int beat = 0; beat <= len; beat++) begin
        rng[m] = next_rand(rng[m]);
        mst_req[m].w.data = rng[m];
        mst_req[m].w.strb = '1;
        mst_req[m].w.last = (beat == len);
        mst_req[m].w_valid = 1'b1;
        t = 0;
        do begin
            @(posedge clk);
            t++;
            assert (!mst_resp[m].b_valid)
                else report_error($sformatf("master %0d got B before its last W", m));
            if (t > TIMEOUT) report_timeout(m, "w_ready");
        end while (!mst_resp[m].w_ready);
        shadow[addr + 32'(4 * beat)] = mst_req[m].w.data;
        @(negedge clk);
    end
    mst_req[m].w_valid = 1'b0;
    mst_req[m].b_ready = 1'b1;
    t = 0;
    do begin
        @(posedge clk);
        t++;
        if (t > TIMEOUT) report_timeout(m, "b_valid");
    end while (!mst_resp[m].b_valid);
    assert (mst_resp[m].b.id == id && mst_resp[m].b.resp == axi_xbar_pkg::RESP_OKAY)
        else report_error($sformatf("master %0d B id %0h resp %0d", m,
                                    mst_resp[m].b.id, mst_resp[m].b.resp));
    @(negedge clk);
    mst_req[m].b_ready = 1'b0;
endtask

task automatic read_burst(input int m, input logic [31:0] addr, input logic [7:0] len);
    int t;
    int beat;
    logic [3:0] id;
    logic done;

    id = 4'(5 + m);
    @(negedge clk);
    mst_req[m].ar.id    = id;
    mst_req[m].ar.addr  = addr;
    mst_req[m].ar.len   = len;
    mst_req[m].ar.burst = 2'b01;
    mst_req[m].ar_valid = 1'b1;
    t = 0;
    do begin
        @(posedge clk);
        t++;
        if (t > TIMEOUT) report_timeout(m, "ar_ready");
    end while (!mst_resp[m].ar_ready);
    beat = 0;
    done = 1'b0;
    t = 0;
    while (!done) begin
        @(negedge clk);
        mst_req[m].ar_valid = 1'b0;
        rng[m] = next_rand(rng[m]);
        mst_req[m].r_ready = rng[m][4];          // random master-side stalls on R.
        @(posedge clk);
        t++;
        if (t > TIMEOUT) report_timeout(m, "read data");
        if (mst_resp[m].r_valid && mst_req[m].r_ready) begin
            assert (mst_resp[m].r.data == shadow[addr + 32'(4 * beat)] &&
                    mst_resp[m].r.id == id && mst_resp[m].r.resp == axi_xbar_pkg::RESP_OKAY &&
                    mst_resp[m].r.last == (beat == len))
                else report_error($sformatf("master %0d beat %0d data %08h id %0h last %0b",
                                            m, beat, mst_resp[m].r.data, mst_resp[m].r.id,
                                            mst_resp[m].r.last));
            done = mst_resp[m].r.last;
            beat++;
        end
    end
    @(negedge clk);
    mst_req[m].r_ready = 1'b0;
endtask

// each master keeps to its own half of the word space so bursts never overlap.
task automatic run_master(input int m);
    logic [31:0] addr;
    logic [7:0]  word;
    logic [7:0]  len;

    for (int it = 0; it < N_ITER; it++) begin
        rng[m] = next_rand(rng[m]);
        word = 8'(m * 128 + rng[m][15:8] % 120);
        len  = 8'(rng[m][3:2]);
        addr = {rng[m][20], 21'd0, word, 2'b00};
        write_burst(m, addr, len);
        last_addr[m] = addr;
        last_len[m]  = len;
        read_burst(m, addr, len);
    end
endtask

initial begin
    reset = 1'b1;
    mst_req[0] = '0;
    mst_req[1] = '0;
    rng[0] = 32'd14;
    rng[1] = next_rand(32'd14);
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    fork
        run_master(0);
        run_master(1);
    join
    // both masters read back together so two AR requests meet at the arbiter.
    fork
        read_burst(0, last_addr[0], last_len[0]);
        read_burst(1, last_addr[1], last_len[1]);
    join
    repeat (5) @(posedge clk);
    $display("TEST PASSED");
    $finish;
end

endmodule

//--- tb.f
source/axi_xbar_pkg.sv
source/axi_master_switch.sv
source/axi_slave_switch.sv
source/axi_txn_arbiter.sv
source/axi_xbar_top.sv
testbench/axi_mem_model.sv
testbench/tb_axi_xbar.sv
